// File: hdl/qcalc_pkg.sv
package qcalc_pkg;

   // datapath widths
   localparam int DATA_WIDTH      = 16;                   // accumulator and result word
   localparam int OPCODE_W        = 4;                    // opcode field at the top of a word
   localparam int IMM_W           = DATA_WIDTH - OPCODE_W; // immediate field below it
   localparam int FIFO_DEPTH_LOG2 = 3;                    // 8 entries per queue

   // plain data word as it sits in a queue or the accumulator
   typedef logic [DATA_WIDTH-1:0] word_t;

   // instruction word layout
   // opcode in the top bits, zero-extended immediate below
   typedef struct packed {
      logic [OPCODE_W-1:0] opcode; // raw code, may hold an unknown value
      logic [IMM_W-1:0]    imm;    // operand, also shift amount in its low 4 bits
   } instr_t;

   // opcodes understood by the machine
   // codes above OP_EMIT are treated as OP_NOP by decode
   typedef enum logic [OPCODE_W-1:0] {
      OP_NOP  = 4'h0, // nothing happens
      OP_LOAD = 4'h1, // acc = imm
      OP_ADD  = 4'h2, // acc = acc + imm, wraps
      OP_SUB  = 4'h3, // acc = acc - imm, wraps
      OP_AND  = 4'h4, // acc = acc & imm
      OP_OR   = 4'h5, // acc = acc | imm
      OP_XOR  = 4'h6, // acc = acc ^ imm
      OP_SHL  = 4'h7, // logical left, imm[3:0] places
      OP_SHR  = 4'h8, // logical right, imm[3:0] places
      OP_EMIT = 4'h9  // push acc into the result queue
   } opcode_e;

endpackage

// File: hdl/sync_fifo.sv
`timescale 1ns/100ps

module sync_fifo #(
   parameter int DATA_WIDTH      = qcalc_pkg::DATA_WIDTH,
   parameter int FIFO_DEPTH_LOG2 = qcalc_pkg::FIFO_DEPTH_LOG2
) (
   input  logic             i_clk,
   input  logic             i_rst_n,
   input  qcalc_pkg::word_t i_item,
   input  logic             i_write,
   input  logic             i_read,
   output qcalc_pkg::word_t o_item,     // show-ahead head
   output logic             o_empty,
   output logic             o_full,
   output logic             o_overrun,  // sticky
   output logic             o_underrun  // sticky
);

   localparam int DEPTH = 1 << FIFO_DEPTH_LOG2;

   logic [DATA_WIDTH-1:0]      mem [DEPTH];
   logic [FIFO_DEPTH_LOG2-1:0] wr_ptr;
   logic [FIFO_DEPTH_LOG2-1:0] rd_ptr;
   logic [FIFO_DEPTH_LOG2-1:0] wr_next;
   logic [FIFO_DEPTH_LOG2-1:0] rd_next;
   logic                       wr_ok;
   logic                       rd_ok;

   assign wr_next = wr_ptr + 1'b1; // pointers wrap on their own width
   assign rd_next = rd_ptr + 1'b1;

   // a write into a full queue only lands when the head leaves in the same cycle
   assign wr_ok = i_write && (!o_full || i_read);
   assign rd_ok = i_read && !o_empty;

   // head is visible before the read strobe
   assign o_item = mem[rd_ptr];

   always_ff @(posedge i_clk) begin
      if (wr_ok)
         mem[wr_ptr] <= i_item;
   end

   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         if (wr_ok)
            wr_ptr <= wr_next;
         if (rd_ok)
            rd_ptr <= rd_next;
      end
   end

   // registered flags, decoded from the strobes and the current flags
   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         o_empty <= 1'b1; // queue starts empty
         o_full  <= 1'b0;
      end else begin
         casez ({i_write, i_read, !o_full, !o_empty})
            4'b01?1: begin               // read only
               o_full  <= 1'b0;
               o_empty <= (rd_next == wr_ptr);
            end
            4'b101?: begin               // write only, room left
               o_full  <= (wr_next == rd_ptr);
               o_empty <= 1'b0;
            end
            4'b11?0: begin               // write lands, read fails on empty
               o_full  <= 1'b0;
               o_empty <= 1'b0;
            end
            4'b11?1: o_empty <= 1'b0;    // both succeed, full holds
            default: ;                   // idle or rejected strobe
         endcase
      end
   end

   // error flags stay up until reset
   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         o_overrun  <= 1'b0;
         o_underrun <= 1'b0;
      end else begin
         if (i_write && !wr_ok)
            o_overrun <= 1'b1;  // word dropped
         if (i_read && o_empty)
            o_underrun <= 1'b1;
      end
   end

endmodule

// File: hdl/instr_decode.sv
`timescale 1ns/100ps

module instr_decode (
   input  logic                        i_clk,
   input  logic                        i_rst_n,
   input  qcalc_pkg::instr_t           i_head,       // show-ahead head of the instruction queue
   input  logic                        i_empty,
   input  logic                        i_emit_ready, // a result slot is free for one more emit
   output logic                        o_pop,
   output logic                        o_reserve,    // pop of an emit, books a result slot
   output logic                        o_valid,
   output qcalc_pkg::opcode_e          o_opcode,
   output logic [qcalc_pkg::IMM_W-1:0] o_imm
);

   import qcalc_pkg::*;

   opcode_e head_op;
   logic    head_is_emit;
   logic    hold;

   // unknown codes fold to a nop here so execute only sees legal opcodes
   always_comb begin
      case (i_head.opcode)
         OP_LOAD, OP_ADD, OP_SUB, OP_AND, OP_OR,
         OP_XOR, OP_SHL, OP_SHR, OP_EMIT:
            head_op = opcode_e'(i_head.opcode);
         default:
            head_op = OP_NOP;
      endcase
   end

   assign head_is_emit = (head_op == OP_EMIT);

   // an emit waits at the head until the result side has room for it
   assign hold = head_is_emit && !i_emit_ready;

   assign o_pop     = !i_empty && !hold; // never reads an empty queue
   assign o_reserve = o_pop && head_is_emit;

   // one valid pulse per popped word
   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         o_valid  <= 1'b0;
         o_opcode <= OP_NOP;
      end else begin
         o_valid  <= o_pop;
         if (o_pop)
            o_opcode <= head_op;
      end
   end

   // immediate rides along with the opcode
   always_ff @(posedge i_clk) begin
      if (o_pop)
         o_imm <= i_head.imm;
   end

endmodule

// File: hdl/alu_execute.sv
`timescale 1ns/100ps

module alu_execute (
   input  logic                        i_clk,
   input  logic                        i_rst_n,
   input  logic                        i_valid,
   input  qcalc_pkg::opcode_e          i_opcode,
   input  logic [qcalc_pkg::IMM_W-1:0] i_imm,
   output logic                        o_emit,       // one-cycle push strobe
   output qcalc_pkg::word_t            o_emit_value,
   output qcalc_pkg::word_t            o_acc         // debug view of the accumulator
);

   import qcalc_pkg::*;

   word_t      acc;
   word_t      acc_next;
   word_t      imm_ext;
   logic [3:0] shamt;
   logic       is_emit;

   assign imm_ext = {{OPCODE_W{1'b0}}, i_imm}; // zero-extended operand
   assign shamt   = i_imm[3:0];                // shifts use the low nibble only
   assign is_emit = i_valid && (i_opcode == OP_EMIT);

   // alu, all arithmetic wraps at the word width
   always_comb begin
      case (i_opcode)
         OP_LOAD: acc_next = imm_ext;
         OP_ADD:  acc_next = acc + imm_ext;
         OP_SUB:  acc_next = acc - imm_ext;
         OP_AND:  acc_next = acc & imm_ext;
         OP_OR:   acc_next = acc | imm_ext;
         OP_XOR:  acc_next = acc ^ imm_ext;
         OP_SHL:  acc_next = acc << shamt;
         OP_SHR:  acc_next = acc >> shamt; // logical, zeros shift in
         default: acc_next = acc;          // nop and emit leave acc alone
      endcase
   end

   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n)
         acc <= '0;
      else if (i_valid)
         acc <= acc_next;
   end

   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n)
         o_emit <= 1'b0;
      else
         o_emit <= is_emit; // one cycle after the decode pulse
   end

   // emit leaves acc unchanged, so this is also the value after the edge
   always_ff @(posedge i_clk) begin
      if (is_emit)
         o_emit_value <= acc;
   end

   assign o_acc = acc;

endmodule

// File: hdl/result_stage.sv
`timescale 1ns/100ps

module result_stage #(
   parameter int DATA_WIDTH      = qcalc_pkg::DATA_WIDTH,
   parameter int FIFO_DEPTH_LOG2 = qcalc_pkg::FIFO_DEPTH_LOG2
) (
   input  logic             i_clk,
   input  logic             i_rst_n,
   input  logic             i_reserve,    // decode popped an emit
   input  logic             i_emit,       // emit value arrives from execute
   input  qcalc_pkg::word_t i_emit_value,
   input  logic             i_read,       // outside pops a result
   output logic             o_emit_ready,
   output qcalc_pkg::word_t o_result,
   output logic             o_empty,
   output logic             o_underrun
);

   localparam int DEPTH = 1 << FIFO_DEPTH_LOG2;
   localparam int CNT_W = FIFO_DEPTH_LOG2 + 1; // must hold DEPTH itself

   logic [CNT_W-1:0] free_cnt; // slots not holding a result
   logic [CNT_W-1:0] rsv_cnt;  // emits popped but not yet written
   logic             fifo_empty;
   logic             rd_ok;

   assign rd_ok = i_read && !fifo_empty; // a read on empty frees nothing

   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         free_cnt <= CNT_W'(DEPTH);
      end else begin
         case ({i_emit, rd_ok})
            2'b10:   free_cnt <= free_cnt - 1'b1;
            2'b01:   free_cnt <= free_cnt + 1'b1;
            default: ; // none, or one in and one out
         endcase
      end
   end

   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         rsv_cnt <= '0;
      end else begin
         case ({i_reserve, i_emit})
            2'b10:   rsv_cnt <= rsv_cnt + 1'b1;
            2'b01:   rsv_cnt <= rsv_cnt - 1'b1;  // booked slot now filled
            default: ;
         endcase
      end
   end

   // room for one more booking
   // every emit in flight already owns a slot, so the write never overflows
   assign o_emit_ready = (free_cnt > rsv_cnt);

   sync_fifo #(
      .DATA_WIDTH      (DATA_WIDTH),
      .FIFO_DEPTH_LOG2 (FIFO_DEPTH_LOG2)
   ) u_result_fifo (
      .i_clk      (i_clk),
      .i_rst_n    (i_rst_n),
      .i_item     (i_emit_value),
      .i_write    (i_emit),
      .i_read     (i_read),
      .o_item     (o_result),
      .o_empty    (fifo_empty),
      .o_full     (),   // reservation keeps writes off a full queue
      .o_overrun  (),
      .o_underrun (o_underrun)
   );

   assign o_empty = fifo_empty;

endmodule

// File: hdl/qcalc_top.sv
`timescale 1ns/100ps

module qcalc_top #(
   parameter int DATA_WIDTH      = qcalc_pkg::DATA_WIDTH,
   parameter int FIFO_DEPTH_LOG2 = qcalc_pkg::FIFO_DEPTH_LOG2
) (
   input  logic              i_clk,
   input  logic              i_rst_n,
   input  qcalc_pkg::instr_t i_instr,
   input  logic              i_instr_write,
   output logic              o_instr_full,
   output logic              o_instr_overrun,
   output qcalc_pkg::word_t  o_result,
   output logic              o_result_empty,
   input  logic              i_result_read,
   output logic              o_result_underrun,
   output qcalc_pkg::word_t  o_acc
);

   import qcalc_pkg::*;

   instr_t           iq_head;    // show-ahead head of the instruction queue
   logic             iq_empty;
   logic             iq_pop;
   logic             reserve;    // emit popped, slot booked
   logic             emit_ready;
   logic             dec_valid;
   opcode_e          dec_opcode;
   logic [IMM_W-1:0] dec_imm;
   logic             emit;
   word_t            emit_value;

   // instruction queue
   sync_fifo #(
      .DATA_WIDTH      (DATA_WIDTH),
      .FIFO_DEPTH_LOG2 (FIFO_DEPTH_LOG2)
   ) u_instr_fifo (
      .i_clk      (i_clk),
      .i_rst_n    (i_rst_n),
      .i_item     (i_instr),
      .i_write    (i_instr_write),
      .i_read     (iq_pop),
      .o_item     (iq_head),
      .o_empty    (iq_empty),
      .o_full     (o_instr_full),
      .o_overrun  (o_instr_overrun),
      .o_underrun ()  // decode never pops an empty queue
   );

   instr_decode u_decode (
      .i_clk        (i_clk),
      .i_rst_n      (i_rst_n),
      .i_head       (iq_head),
      .i_empty      (iq_empty),
      .i_emit_ready (emit_ready),
      .o_pop        (iq_pop),
      .o_reserve    (reserve),
      .o_valid      (dec_valid),
      .o_opcode     (dec_opcode),
      .o_imm        (dec_imm)
   );

   alu_execute u_execute (
      .i_clk        (i_clk),
      .i_rst_n      (i_rst_n),
      .i_valid      (dec_valid),
      .i_opcode     (dec_opcode),
      .i_imm        (dec_imm),
      .o_emit       (emit),
      .o_emit_value (emit_value),
      .o_acc        (o_acc)
   );

   result_stage #(
      .DATA_WIDTH      (DATA_WIDTH),
      .FIFO_DEPTH_LOG2 (FIFO_DEPTH_LOG2)
   ) u_result (
      .i_clk        (i_clk),
      .i_rst_n      (i_rst_n),
      .i_reserve    (reserve),
      .i_emit       (emit),
      .i_emit_value (emit_value),
      .i_read       (i_result_read),
      .o_emit_ready (emit_ready),
      .o_result     (o_result),
      .o_empty      (o_result_empty),
      .o_underrun   (o_result_underrun)
   );

endmodule

// File: verification/qcalc_tb.sv
`timescale 1ns/100ps

module qcalc_tb;

   import qcalc_pkg::*;

   localparam int CLK_PERIOD  = 20;
   localparam int LINE_CYCLES = 200; // watchdog budget per data line
   localparam int WAIT_CYCLES = 200; // longest wait for one result

   logic   clk;
   logic   rst_n;
   instr_t instr;
   logic   instr_write;
   logic   instr_full;
   logic   instr_overrun;
   word_t  result;
   logic   result_empty;
   logic   result_read;
   logic   result_underrun;
   word_t  acc;

   int     entry_count = 0; // data lines, comments excluded
   bit     counted     = 1'b0;
   word_t  exp_acc     = '0; // accumulator as the opcode rules predict it

   qcalc_top #(
      .DATA_WIDTH      (DATA_WIDTH),
      .FIFO_DEPTH_LOG2 (FIFO_DEPTH_LOG2)
   ) i_dut (
      .i_clk             (clk),
      .i_rst_n           (rst_n),
      .i_instr           (instr),
      .i_instr_write     (instr_write),
      .o_instr_full      (instr_full),
      .o_instr_overrun   (instr_overrun),
      .o_result          (result),
      .o_result_empty    (result_empty),
      .i_result_read     (result_read),
      .o_result_underrun (result_underrun),
      .o_acc             (acc)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   task automatic report_failure(input string msg);
      $display("%s", msg);
      $display("Simulation failed");
      $fatal(1);
   endtask

   task automatic check_word(input string name, input word_t expected, input word_t actual);
      if (actual !== expected)
         report_failure($sformatf("Mismatch in %s: expected %h, actual %h",
                                  name, expected, actual));
   endtask

   task automatic check_flag(input string name, input logic expected, input logic actual);
      if (actual !== expected)
         report_failure($sformatf("Mismatch in %s: expected %b, actual %b",
                                  name, expected, actual));
   endtask

   // accumulator after one instruction, unknown codes leave it alone
   function automatic word_t apply_instr(input word_t acc_in, input instr_t word);
      word_t imm;
      word_t res;
      imm                = '0;
      imm[IMM_W-1:0]     = word.imm; // zero-extended operand
      case (word.opcode)
         OP_LOAD: res = imm;
         OP_ADD:  res = acc_in + imm;   // wraps at the word width
         OP_SUB:  res = acc_in - imm;
         OP_AND:  res = acc_in & imm;
         OP_OR:   res = acc_in | imm;
         OP_XOR:  res = acc_in ^ imm;
         OP_SHL:  res = acc_in << word.imm[3:0];
         OP_SHR:  res = acc_in >> word.imm[3:0];
         default: res = acc_in;         // nop and emit
      endcase
      return res;
   endfunction

   task automatic open_data(output int fd);
      fd = $fopen("verification/qcalc_testdata.txt", "r");
      if (fd == 0)
         report_failure("cannot open verification/qcalc_testdata.txt for reading");
   endtask

   // next command line, lines starting with # are skipped
   task automatic next_entry(input int fd, output bit got, output string name,
                             output string cmd, output word_t value);
      string          tok;
      int             n;
      logic [8*256-1:0] rest;
      got = 1'b0;
      while (!got) begin
         n = $fscanf(fd, "%s", tok);
         if (n != 1)
            return;                 // end of file
         if (tok[0] == "#") begin
            n = $fgets(rest, fd);   // drop the rest of the comment
         end else begin
            name = tok;
            n    = $fscanf(fd, "%s %h", cmd, value);
            got  = (n == 2);
            if (!got)
               return;
         end
      end
   endtask

   task automatic write_word(input word_t value);
      logic dropped;
      @(posedge clk);
      instr       <= value;
      instr_write <= 1'b1;
      @(negedge clk);
      dropped = instr_full;    // full queue refuses the word at the next edge
      @(posedge clk);          // word lands here
      instr_write <= 1'b0;
      if (!dropped)
         exp_acc = apply_instr(exp_acc, value);
   endtask

   task automatic pulse_read();
      @(posedge clk);
      result_read <= 1'b1;
      @(posedge clk);          // head leaves here
      result_read <= 1'b0;
   endtask

   // random idle gap, then wait for a result, check the head and pop it
   task automatic read_result(input string name, input word_t expected);
      int gap;
      int waited;
      gap    = $urandom % 4;
      waited = 0;
      repeat (gap) @(posedge clk);
      @(negedge clk);
      while (result_empty) begin
         if (waited == WAIT_CYCLES)
            report_failure($sformatf("no result arrived for %s within %0d cycles",
                                     name, WAIT_CYCLES));
         else begin
            waited++;
            @(negedge clk);
         end
      end
      check_word(name, expected, result);
      pulse_read();
   endtask

   // value[7:4] picks the flag, value[0] is its expected level
   task automatic check_selected_flag(input string name, input word_t value);
      logic actual;
      if (value[7:4] > 4'h3) begin
         report_failure($sformatf("test %s names flag %0d, which does not exist",
                                  name, value[7:4]));
      end else begin
         case (value[7:4])
            4'h0:    actual = result_empty;
            4'h1:    actual = instr_full;
            4'h2:    actual = instr_overrun;
            default: actual = result_underrun;
         endcase
         check_flag(name, value[0], actual);
      end
   endtask

   // watchdog, sized from the data file once it has been counted
   initial begin
      wait (counted);
      #(entry_count * LINE_CYCLES * CLK_PERIOD);
      $display("watchdog expired: %0d data lines did not finish in time", entry_count);
      $display("Simulation failed");
      $fatal(1);
   end

   initial begin
      int    fd;
      bit    got;
      string name;
      string cmd;
      word_t value;
      int    first_draw;
      rst_n       = 1'b0;   // reset from time zero
      instr       = '0;
      instr_write = 1'b0;
      result_read = 1'b0;
      first_draw  = $urandom(32'he831); // seeds the gap generator
      open_data(fd);
      next_entry(fd, got, name, cmd, value);
      while (got) begin
         entry_count++;
         next_entry(fd, got, name, cmd, value);
      end
      $fclose(fd);
      counted = 1'b1;
      open_data(fd);
      repeat (4) @(posedge clk);
      rst_n <= 1'b1;
      next_entry(fd, got, name, cmd, value);
      while (got) begin
         if (cmd == "W")
            write_word(value);
         else if (cmd == "R")
            read_result(name, value);
         else if (cmd == "F") begin
            @(negedge clk);  // flags settled
            check_selected_flag(name, value);
         end else if (cmd == "H")
            repeat (value) @(posedge clk);
         else if (cmd == "X")
            pulse_read();    // read without looking at empty
         else
            report_failure($sformatf("unknown command %s in test %s", cmd, name));
         next_entry(fd, got, name, cmd, value);
      end
      $fclose(fd);
      @(posedge clk);
      @(negedge clk);        // pipeline long drained, acc at rest
      check_word("acc_drain", exp_acc, acc);
      $display("Simulation passed");
      $finish;
   end

endmodule

// File: verification/qcalc_testdata.txt
# columns: test name, command, hex value. W write word, R expect head then read,
# F flag value[7:4] (0 res_empty 1 instr_full 2 instr_ovr 3 res_unr) = value[0], H idle, X read
rst_empty F 01
rst_full F 10
rst_ovr F 20
rst_unr F 30
rst_emit W 9000
rst_emit R 0000
load W 1ABC
load W 9000
load R 0ABC
shl4 W 1FFF
shl4 W 7004
shl4 W 9000
shl4 R FFF0
add_wrap W 2020
add_wrap W 9000
add_wrap R 0010
sub_wrap W 3011
sub_wrap W 9000
sub_wrap R FFFF
and W 4F0F
and W 9000
and R 0F0F
or W 50F0
or W 9000
or R 0FFF
xor W 6A5A
xor W 9000
xor R 05A5
shr0 W 8010
shr0 W 9000
shr0 R 05A5
shl15 W 700F
shl15 W 9000
shl15 R 8000
shr15 W 800F
shr15 W 9000
shr15 R 0001
nop W 0123
nop W F456
nop W 9000
nop R 0001
bp W 1000
bp W 2001
bp W 9000
bp W 2001
bp W 9000
bp W 2001
bp W 9000
bp W 2001
bp W 9000
bp W 2001
bp W 9000
bp W 2001
bp W 9000
bp W 2001
bp W 9000
bp W 2001
bp W 9000
bp W 2001
bp W 9000
bp W 2001
bp W 9000
bp W 2001
bp W 9000
bp W 2001
bp W 9000
bp_fill W 2100
bp_full F 11
bp_drop W 9000
bp_ovr F 21
bp_queued F 00
bp R 0001
bp R 0002
bp R 0003
bp R 0004
bp R 0005
bp R 0006
bp R 0007
bp R 0008
bp R 0009
bp R 000A
bp R 000B
bp R 000C
drain H 10
drain F 01
drain F 30
drain F 10
unr X 0
unr F 31
unr H 4
unr F 31

// File: verilog.f
hdl/qcalc_pkg.sv
hdl/sync_fifo.sv
hdl/instr_decode.sv
hdl/alu_execute.sv
hdl/result_stage.sv
hdl/qcalc_top.sv
verification/qcalc_tb.sv

// File: Bender.yml
package:
  name: qcalc

sources:
  - hdl/qcalc_pkg.sv
  - hdl/sync_fifo.sv
  - hdl/instr_decode.sv
  - hdl/alu_execute.sv
  - hdl/result_stage.sv
  - hdl/qcalc_top.sv
  - target: simulation
    files:
      - verification/qcalc_tb.sv
